// ==== list.f ====
+incdir+logic
logic/agcPkg.sv
logic/agcSettingsIf.sv
logic/agcLoopRegs.sv
logic/agcErrorGen.sv
logic/agcIntegrator.sv
logic/agcLoop.sv
dv/agcClkGen.sv
dv/agcLoopTb.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = agcLoopTb
FILELIST   = list.f
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
OBJDIR     = obj_dir
PASS_TEXT  = ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== dv/agcLoopTb.sv ====
// Testbench of the AGC loop block.
// Random bus traffic and level samples from a fixed LCG seed are checked
// against a register and integrator model kept in the testbench.

`default_nettype none

`include "agcLoop_config.svh"

module agcLoopTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED = 32'h58af00ee;
    localparam int RAND_WRITES  = 150;
    localparam int ROUNDS       = 9;
    localparam int SAMPLE_TICKS = 120;
    localparam int DRAIN_TICKS  = 8;
    localparam int RESET_LEN  = 4;
    localparam int WRITE_LEN  = RAND_WRITES + 5 * ROUNDS;
    localparam int READ_LEN   = 16 + 2 * RAND_WRITES + ROUNDS;
    localparam int SAMPLE_LEN = ROUNDS * (SAMPLE_TICKS + DRAIN_TICKS);
    localparam int CYCLE_LIMIT = 2 * (RESET_LEN + WRITE_LEN + READ_LEN + SAMPLE_LEN);

    typedef logic [7:0] gainByteT; // Top byte of accT.

    logic                       busClk;
    logic                       rstN;
    logic [`AGC_ADDR_WIDTH-1:0] addr;
    agcPkg::busWordT            dataIn;
    logic                       cs;
    logic [3:0]                 byteWr;
    agcPkg::levelT              level;
    logic                       levelValid;
    agcPkg::busWordT            dataOut;
    logic [7:0]                 agcGain;
    logic                       agcGainValid;

    logic [31:0]   lcgState = SEED;
    int            cycleCount = 0;
    int            upperHits;
    int            lowerHits;
    gainByteT      expGain[$];

    // Shadow registers and model integrator.
    agcPkg::levelT refSetpoint;
    logic          refInvert;
    logic          refZero;
    agcPkg::shiftT refPosGain;
    agcPkg::shiftT refNegGain;
    agcPkg::accT   refUpper;
    agcPkg::accT   refLower;
    agcPkg::accT   refInteg;

    agcClkGen u_clkGen (.busClk(busClk));

    agcLoop u_dut (
        .busClk       (busClk),
        .rstN         (rstN),
        .addr         (addr),
        .dataIn       (dataIn),
        .cs           (cs),
        .byteWr       (byteWr),
        .level        (level),
        .levelValid   (levelValid),
        .dataOut      (dataOut),
        .agcGain      (agcGain),
        .agcGainValid (agcGainValid)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    always @(posedge busClk) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            abortRun($sformatf("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic agcPkg::shiftT randShift(input int lo, input int hi);
        int pick;
        pick = lo + int'((nextRand() >> 8) % 32'(hi - lo + 1));
        return pick[4:0];
    endfunction

    function automatic logic [`AGC_ADDR_WIDTH-1:0] pickAddr();
        logic [31:0] r;
        r = nextRand();
        case (r[26:24])
            3'd0:    return `AGC_REG_CONTROL;
            3'd1:    return `AGC_REG_SETPOINT;
            3'd2:    return `AGC_REG_GAINS;
            3'd3:    return `AGC_REG_ULIMIT;
            3'd4:    return `AGC_REG_LLIMIT;
            3'd5:    return `AGC_REG_INTEGRATOR;
            3'd6:    return 13'h018; // First unmapped word.
            default: return r[12:0];
        endcase
    endfunction

    task automatic checkWord(input string name, input agcPkg::busWordT expected,
                             input agcPkg::busWordT actual);
        if (actual !== expected) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s expected 0x%08h, actual 0x%08h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic checkGain(input string name, input gainByteT expected, input gainByteT actual);
        if (actual !== expected) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s expected 0x%02h, actual 0x%02h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic applyWrite(input logic [`AGC_ADDR_WIDTH-1:0] a, input agcPkg::busWordT d,
                              input logic [3:0] s);
        case (a)
            `AGC_REG_CONTROL: begin
                if (s[0]) begin
                    refZero   = d[0];
                    refInvert = d[1];
                end
            end
            `AGC_REG_SETPOINT: begin
                if (s[0]) refSetpoint = d[7:0];
            end
            `AGC_REG_GAINS: begin
                if (s[0]) refPosGain = d[4:0];
                if (s[2]) refNegGain = d[20:16];
            end
            `AGC_REG_ULIMIT: begin
                for (int i = 0; i < 4; i++) begin
                    if (s[i]) refUpper[8*i +: 8] = d[8*i +: 8];
                end
            end
            `AGC_REG_LLIMIT: begin
                for (int i = 0; i < 4; i++) begin
                    if (s[i]) refLower[8*i +: 8] = d[8*i +: 8];
                end
            end
            default: ;
        endcase
    endtask

    function automatic agcPkg::busWordT expectedRead(input logic [`AGC_ADDR_WIDTH-1:0] a);
        case (a)
            `AGC_REG_CONTROL:    return {30'd0, refInvert, refZero};
            `AGC_REG_SETPOINT:   return {24'd0, refSetpoint};
            `AGC_REG_GAINS:      return {11'd0, refNegGain, 11'd0, refPosGain};
            `AGC_REG_ULIMIT:     return refUpper;
            `AGC_REG_LLIMIT:     return refLower;
            `AGC_REG_INTEGRATOR: return refInteg;
            default:             return '0;
        endcase
    endfunction

    // One accepted sample through the loop rules.
    task automatic predictSample(input agcPkg::levelT lvl);
        int            err;
        agcPkg::shiftT shift;
        longint        wide;
        agcPkg::accT   scaled;
        longint        sum;
        err = int'(refSetpoint) - int'(lvl);
        if (refZero) begin
            err = 0;
        end else if (refInvert) begin
            err = -err;
        end
        shift = (err < 0) ? refNegGain : refPosGain;
        wide = longint'(err) << shift;
        scaled = wide[31:0]; // Wraps like a 32-bit shift.
        sum = longint'(refInteg) + longint'(scaled);
        if (sum > longint'(refUpper)) begin
            refInteg = refUpper;
            upperHits++;
        end else if (sum < longint'(refLower)) begin
            refInteg = refLower;
            lowerHits++;
        end else begin
            refInteg = sum[31:0];
        end
        expGain.push_back(refInteg[`AGC_GAIN_MSB -: 8]);
    endtask

    // Next edge, then check any gain pulse before new inputs go out.
    task automatic tick();
        @(posedge busClk);
        #1;
        if (agcGainValid === 1'b1) begin
            if (expGain.size() == 0) begin
                abortRun("agcGainValid pulsed with no level sample pending");
            end else begin
                checkGain("agcGain", expGain.pop_front(), agcGain);
            end
        end
    endtask

    task automatic busWrite(input logic [`AGC_ADDR_WIDTH-1:0] a, input agcPkg::busWordT d,
                            input logic [3:0] s);
        tick();
        addr = a;
        dataIn = d;
        cs = 1'b1;
        byteWr = s;
        levelValid = 1'b0;
        applyWrite(a, d, s);
    endtask

    task automatic busRead(input logic [`AGC_ADDR_WIDTH-1:0] a);
        tick();
        addr = a;
        dataIn = nextRand();
        cs = 1'b1;
        byteWr = '0;
        levelValid = 1'b0;
        #1;
        checkWord($sformatf("dataOut[0x%03h]", a), expectedRead(a), dataOut);
    endtask

    task automatic idleRead(input logic [`AGC_ADDR_WIDTH-1:0] a);
        logic [31:0] r;
        r = nextRand();
        tick();
        addr = a;
        dataIn = nextRand();
        cs = 1'b0;
        byteWr = r[19:16]; // Ignored while cs is low.
        levelValid = 1'b0;
        #1;
        checkWord("dataOut with cs low", '0, dataOut);
    endtask

    task automatic readAll();
        busRead(`AGC_REG_CONTROL);
        busRead(`AGC_REG_SETPOINT);
        busRead(`AGC_REG_GAINS);
        busRead(`AGC_REG_ULIMIT);
        busRead(`AGC_REG_LLIMIT);
        busRead(`AGC_REG_INTEGRATOR);
        busRead(13'h018);
        busRead(13'h1FFC);
    endtask

    task automatic runSamples(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            tick();
            r = nextRand();
            cs = 1'b0;
            byteWr = '0;
            level = r[23:16];
            levelValid = (r[30:29] != 2'b00);
            if (levelValid) predictSample(r[23:16]);
        end
        tick();
        levelValid = 1'b0;
        while (expGain.size() != 0) begin
            tick();
        end
        repeat (2) tick(); // No stray pulses.
    endtask

    task automatic runRound(input agcPkg::levelT sp, input logic inv, input logic zero,
                            input agcPkg::shiftT pos, input agcPkg::shiftT neg,
                            input agcPkg::accT upper, input agcPkg::accT lower);
        busWrite(`AGC_REG_CONTROL, {30'd0, inv, zero}, 4'hF);
        busWrite(`AGC_REG_SETPOINT, {24'd0, sp}, 4'hF);
        busWrite(`AGC_REG_GAINS, {11'd0, neg, 11'd0, pos}, 4'hF);
        busWrite(`AGC_REG_ULIMIT, upper, 4'hF);
        busWrite(`AGC_REG_LLIMIT, lower, 4'hF);
        runSamples(SAMPLE_TICKS);
        busRead(`AGC_REG_INTEGRATOR);
    endtask

    initial begin
        logic [`AGC_ADDR_WIDTH-1:0] a;
        logic [31:0]                r;
        agcPkg::accT                upper;
        agcPkg::accT                lower;
        rstN = 1'b0;
        addr = '0;
        dataIn = '0;
        cs = 1'b0;
        byteWr = '0;
        level = '0;
        levelValid = 1'b0;
        refSetpoint = `AGC_RST_SETPOINT;
        refInvert = 1'b0;
        refZero = 1'b0;
        refPosGain = '0;
        refNegGain = '0;
        refUpper = `AGC_RST_ULIMIT;
        refLower = `AGC_RST_LLIMIT;
        refInteg = '0;
        upperHits = 0;
        lowerHits = 0;

        repeat (RESET_LEN) tick();
        rstN = 1'b1;
        checkGain("agcGain", 8'h00, agcGain);
        readAll();

        for (int i = 0; i < RAND_WRITES; i++) begin
            a = pickAddr();
            r = nextRand();
            busWrite(a, nextRand(), r[19:16]);
            busRead(a);
            idleRead(pickAddr());
        end
        readAll();

        for (int i = 0; i < 2; i++) begin
            r = nextRand();
            runRound(r[23:16], 1'b0, 1'b0, randShift(0, 20), randShift(0, 20),
                     `AGC_RST_ULIMIT, `AGC_RST_LLIMIT);
        end

        // Inversion, zeroing, and both at once.
        r = nextRand();
        runRound(r[23:16], 1'b1, 1'b0, randShift(0, 20), randShift(0, 20),
                 `AGC_RST_ULIMIT, `AGC_RST_LLIMIT);
        runRound(r[15:8], 1'b0, 1'b1, randShift(0, 20), randShift(0, 20),
                 `AGC_RST_ULIMIT, `AGC_RST_LLIMIT);
        runRound(r[31:24], 1'b1, 1'b1, randShift(0, 20), randShift(0, 20),
                 `AGC_RST_ULIMIT, `AGC_RST_LLIMIT);

        upperHits = 0;
        lowerHits = 0;
        for (int i = 0; i < 4; i++) begin
            r = nextRand();
            upper = {6'd0, r[25:0]};
            upper = upper + 1;
            r = nextRand();
            lower = {6'd0, r[25:0]};
            lower = -lower - 1;
            r = nextRand();
            // Full scale setpoints push each way first.
            if (i == 0) begin
                r[23:16] = 8'hFF;
            end else if (i == 1) begin
                r[23:16] = 8'h00;
            end
            runRound(r[23:16], 1'b0, 1'b0, randShift(16, 22), randShift(16, 22), upper, lower);
        end

        if (upperHits == 0 || lowerHits == 0) begin
            abortRun("The integrator did not reach both of its limits");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== dv/agcClkGen.sv ====
// Free running bus clock for the AGC loop testbench.
// Starts low and toggles every half period.

`default_nettype none

module agcClkGen #(
    parameter realtime period = 4.0
) (
    output logic busClk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial busClk = 1'b0;

    always #(period / 2.0) busClk = ~busClk;

endmodule

`default_nettype wire

// ==== logic/agcLoop.sv ====
// Top of the AGC loop block.
// Connects the bus register bank, the error stage and the integrator.
// A level sample accepted on one edge updates the gain two edges later.

`default_nettype none

`include "agcLoop_config.svh"

module agcLoop (
    input  wire logic                       busClk,
    input  wire logic                       rstN,
    input  wire logic [`AGC_ADDR_WIDTH-1:0] addr,
    input  wire agcPkg::busWordT            dataIn,
    input  wire logic                       cs,
    input  wire logic [3:0]                 byteWr,
    input  wire agcPkg::levelT              level,
    input  wire logic                       levelValid,
    output agcPkg::busWordT                 dataOut,
    output logic [7:0]                      agcGain,
    output logic                            agcGainValid
);

    agcPkg::accT scaledErr;
    logic        errValid;
    agcPkg::accT integrator;

    agcSettingsIf settingsIf ();

    agcLoopRegs u_regs (
        .busClk     (busClk),
        .rstN       (rstN),
        .addr       (addr),
        .dataIn     (dataIn),
        .cs         (cs),
        .byteWr     (byteWr),
        .dataOut    (dataOut),
        .integrator (integrator),
        .settings   (settingsIf.regs)
    );

    agcErrorGen u_errorGen (
        .busClk     (busClk),
        .rstN       (rstN),
        .level      (level),
        .levelValid (levelValid),
        .settings   (settingsIf.loop),
        .scaledErr  (scaledErr),
        .errValid   (errValid)
    );

    agcIntegrator u_integrator (
        .busClk       (busClk),
        .rstN         (rstN),
        .scaledErr    (scaledErr),
        .errValid     (errValid),
        .settings     (settingsIf.loop),
        .integrator   (integrator),
        .agcGain      (agcGain),
        .agcGainValid (agcGainValid)
    );

endmodule

`default_nettype wire

// ==== logic/agcIntegrator.sv ====
// Clamped integrator of the AGC loop.
// Adds each valid scaled error at full precision, clamps to the signed
// limits and drives the top byte out as the gain control word.

`default_nettype none

`include "agcLoop_config.svh"

module agcIntegrator (
    input  wire logic         busClk,
    input  wire logic         rstN,
    input  wire agcPkg::accT  scaledErr,
    input  wire logic         errValid,
    agcSettingsIf.loop        settings,
    output agcPkg::accT       integrator,
    output logic [7:0]        agcGain,
    output logic              agcGainValid
);

    logic signed [32:0] sum;
    logic signed [32:0] upperExt;
    logic signed [32:0] lowerExt;
    agcPkg::accT        clamped;

    // One guard bit keeps the sum exact.
    assign sum      = $signed({integrator[31], integrator}) + $signed({scaledErr[31], scaledErr});
    assign upperExt = {settings.upperLimit[31], settings.upperLimit};
    assign lowerExt = {settings.lowerLimit[31], settings.lowerLimit};

    always_comb begin
        if (sum > upperExt) begin
            clamped = settings.upperLimit;
        end else if (sum < lowerExt) begin
            clamped = settings.lowerLimit;
        end else begin
            clamped = sum[31:0];
        end
    end

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            integrator   <= '0;
            agcGainValid <= 1'b0;
        end else begin
            if (errValid) begin
                integrator <= clamped;
            end
            agcGainValid <= errValid; // High the cycle after an update.
        end
    end

    assign agcGain = integrator[`AGC_GAIN_MSB -: 8];

endmodule

`default_nettype wire

// ==== logic/agcErrorGen.sv ====
// Error stage of the AGC loop.
// Each accepted level gives one scaled error, registered on the next edge
// together with errValid. The gain is chosen by the sign of the error.

`default_nettype none

module agcErrorGen (
    input  wire logic          busClk,
    input  wire logic          rstN,
    input  wire agcPkg::levelT level,
    input  wire logic          levelValid,
    agcSettingsIf.loop         settings,
    output agcPkg::accT        scaledErr,
    output logic               errValid
);

    agcPkg::errT   rawErr;
    agcPkg::errT   condErr;
    agcPkg::accT   extErr;
    agcPkg::shiftT shift;
    agcPkg::accT   scaledNext;

    // Both operands fit in 9 bits, so no overflow.
    assign rawErr = $signed({1'b0, settings.setpoint}) - $signed({1'b0, level});

    always_comb begin
        if (settings.zeroError) begin
            condErr = '0; // Zeroing wins over inversion.
        end else if (settings.invertError) begin
            condErr = -rawErr;
        end else begin
            condErr = rawErr;
        end
    end

    assign extErr = {{23{condErr[8]}}, condErr};

    // Zero counts as positive.
    assign shift = condErr[8] ? settings.negErrorGain : settings.posErrorGain;

    assign scaledNext = extErr <<< shift;

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            errValid <= 1'b0;
        end else begin
            errValid <= levelValid;
        end
    end

    always_ff @(posedge busClk) begin
        if (levelValid) begin
            scaledErr <= scaledNext;
        end
    end

endmodule

`default_nettype wire

// ==== logic/agcLoopRegs.sv ====
// Bus register bank of the AGC loop.
// Writes go per byte lane on busClk, reads are combinational while cs is
// high. Unmapped offsets and unused bits read as zero.

`default_nettype none

`include "agcLoop_config.svh"

module agcLoopRegs (
    input  wire logic                       busClk,
    input  wire logic                       rstN,
    input  wire logic [`AGC_ADDR_WIDTH-1:0] addr,
    input  wire agcPkg::busWordT            dataIn,
    input  wire logic                       cs,
    input  wire logic [3:0]                 byteWr,
    output agcPkg::busWordT                 dataOut,
    input  wire agcPkg::accT                integrator,
    agcSettingsIf.regs                      settings
);

    agcPkg::levelT setpoint;
    logic          invertError;
    logic          zeroError;
    agcPkg::shiftT posErrorGain;
    agcPkg::shiftT negErrorGain;
    agcPkg::accT   upperLimit;
    agcPkg::accT   lowerLimit;

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            setpoint     <= `AGC_RST_SETPOINT;
            invertError  <= 1'b0;
            zeroError    <= 1'b0;
            posErrorGain <= '0;
            negErrorGain <= '0;
            upperLimit   <= `AGC_RST_ULIMIT;
            lowerLimit   <= `AGC_RST_LLIMIT;
        end else if (cs) begin
            case (addr)
                `AGC_REG_CONTROL: begin
                    if (byteWr[0]) begin
                        zeroError   <= dataIn[0];
                        invertError <= dataIn[1];
                    end
                end
                `AGC_REG_SETPOINT: begin
                    if (byteWr[0]) setpoint <= dataIn[7:0];
                end
                `AGC_REG_GAINS: begin
                    if (byteWr[0]) posErrorGain <= dataIn[4:0];
                    if (byteWr[2]) negErrorGain <= dataIn[20:16];
                end
                `AGC_REG_ULIMIT: begin
                    for (int lane = 0; lane < 4; lane++) begin
                        if (byteWr[lane]) upperLimit[8*lane +: 8] <= dataIn[8*lane +: 8];
                    end
                end
                `AGC_REG_LLIMIT: begin
                    for (int lane = 0; lane < 4; lane++) begin
                        if (byteWr[lane]) lowerLimit[8*lane +: 8] <= dataIn[8*lane +: 8];
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        dataOut = '0;
        if (cs) begin
            case (addr)
                `AGC_REG_CONTROL:    dataOut = {30'd0, invertError, zeroError};
                `AGC_REG_SETPOINT:   dataOut = {24'd0, setpoint};
                `AGC_REG_GAINS:      dataOut = {11'd0, negErrorGain, 11'd0, posErrorGain};
                `AGC_REG_ULIMIT:     dataOut = upperLimit;
                `AGC_REG_LLIMIT:     dataOut = lowerLimit;
                `AGC_REG_INTEGRATOR: dataOut = integrator; // Live value.
                default:             dataOut = '0;
            endcase
        end
    end

    assign settings.setpoint     = setpoint;
    assign settings.invertError  = invertError;
    assign settings.zeroError    = zeroError;
    assign settings.posErrorGain = posErrorGain;
    assign settings.negErrorGain = negErrorGain;
    assign settings.upperLimit   = upperLimit;
    assign settings.lowerLimit   = lowerLimit;

endmodule

`default_nettype wire

// ==== logic/agcSettingsIf.sv ====
// Programmed loop settings, from the register bank to the loop stages.
// The bank drives through modport regs, the datapath reads through loop.

`default_nettype none

interface agcSettingsIf;

    agcPkg::levelT setpoint;
    logic          invertError;
    logic          zeroError;
    agcPkg::shiftT posErrorGain;
    agcPkg::shiftT negErrorGain;
    agcPkg::accT   upperLimit;  // Signed.
    agcPkg::accT   lowerLimit;  // Signed.

    modport regs (
        output setpoint, invertError, zeroError,
        output posErrorGain, negErrorGain,
        output upperLimit, lowerLimit
    );

    modport loop (
        input setpoint, invertError, zeroError,
        input posErrorGain, negErrorGain,
        input upperLimit, lowerLimit
    );

endinterface

`default_nettype wire

// ==== logic/agcPkg.sv ====
// Shared types of the AGC loop datapath and its register bank.
// Referenced by scoped names from the RTL and the testbench.

`default_nettype none

package agcPkg;

    // Detected level, also the setpoint.
    typedef logic [7:0] levelT;

    // Setpoint minus level, one bit wider and signed.
    typedef logic signed [8:0] errT;

    // Left shift amount of a loop gain.
    typedef logic [4:0] shiftT;

    // Scaled error, integrator and limits.
    typedef logic signed [31:0] accT;

    typedef logic [31:0] busWordT;

endpackage

`default_nettype wire

// ==== logic/agcLoop_config.svh ====
// Address map, reset values and output position for the AGC loop.
// Include wherever a register offset or a reset constant is needed.

`ifndef AGC_LOOP_CONFIG_SVH
`define AGC_LOOP_CONFIG_SVH

`define AGC_ADDR_WIDTH      13

`define AGC_REG_CONTROL     13'h000
`define AGC_REG_SETPOINT    13'h004
`define AGC_REG_GAINS       13'h008
`define AGC_REG_ULIMIT      13'h00C
`define AGC_REG_LLIMIT      13'h010
`define AGC_REG_INTEGRATOR  13'h014 // Read only.

`define AGC_RST_SETPOINT    8'h80
`define AGC_RST_ULIMIT      32'h7FFF_FFFF
`define AGC_RST_LLIMIT      32'h8000_0000

`define AGC_GAIN_MSB        31 // Top bit of the gain control byte.

`endif
